// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := aexmFrontEndTb
FILELIST  := aexmFrontEnd.f
OBJDIR    := obj_dir
SIM       := $(OBJDIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST)) aexm_defs.svh

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	@if grep -q "Finished with errors" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "Finished with no errors" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

// ==== aexmBpcu.sv ====
`timescale 1ns/1ps
`include "aexm_defs.svh"

module aexmBpcu
  import aexmIsaPkg::*, aexmPipePkg::*;
(
  input  logic gclk,
  input  logic grst,
  input  logic issue,
  input  instT issueInst,
  input  wordT regA,
  input  pcT   target,
  input  logic fetchAdvance,
  output pcT   fetchPc,
  output logic redirect,
  output pcT   redirectPc
);

  opcodeT opc;
  regIdxT rdField;
  regIdxT raField;
  condT   cond;
  logic   isBri;
  logic   isBcc;
  logic   regZero;
  logic   regNeg;
  logic   leTrue;
  logic   condTaken;
  logic   taken;
  logic   wantDelay;
  // taken delayed branch waiting for its slot
  logic   delayPending;
  pcT     delayTarget;
  pcT     nextFetchPc;

  assign opc = instOpc(issueInst);
  assign rdField = instRd(issueInst);
  assign raField = instRa(issueInst);
  assign cond = condT'(rdField[2:0]);

  assign isBri = (opc == opBri);
  assign isBcc = (opc == opBcci);

  // all compares are against zero
  assign regZero = (regA == '0);
  assign regNeg = regA[31];
  assign leTrue = regNeg || regZero;

  always_comb begin
    case (cond)
      condEq: condTaken = regZero;
      condNe: condTaken = !regZero;
      condLt: condTaken = regNeg;
      condLe: condTaken = leTrue;
      // gt as an inverted le
      condGt: condTaken = !leTrue;
      condGe: condTaken = !regNeg;
      default: condTaken = 1'b0;
    endcase
  end

  // unconditional branch always taken
  assign taken = isBri || (isBcc && condTaken);
  // delay bit sits in ra for bri, in rd for bcci
  assign wantDelay = isBri ? raField[4] : rdField[4];

  always_ff @(posedge gclk) begin
    if (grst) begin
      redirect <= 1'b0;
      delayPending <= 1'b0;
    end else begin
      redirect <= 1'b0;
      if (issue) begin
        if (delayPending) begin
          // delay slot just issued, now leave
          redirect <= 1'b1;
          delayPending <= 1'b0;
        end else if (taken && !wantDelay) begin
          redirect <= 1'b1;
        end else if (taken) begin
          delayPending <= 1'b1;
        end
      end
    end
  end

  // redirect target and parked delay target
  always_ff @(posedge gclk) begin
    if (issue && delayPending) begin
      redirectPc <= delayTarget;
    end else if (issue && taken && !wantDelay) begin
      redirectPc <= target;
    end
    if (issue && !delayPending && taken && wantDelay) begin
      delayTarget <= target;
    end
  end

  // fetch PC, redirect wins over sequential advance
  always_comb begin
    if (redirect) begin
      nextFetchPc = redirectPc;
    end else if (fetchAdvance) begin
      nextFetchPc = fetchPc + 1'b1;
    end else begin
      nextFetchPc = fetchPc;
    end
  end

  always_ff @(posedge gclk) begin
    if (grst) begin
      fetchPc <= `AEXM_RESET_PC;
    end else begin
      fetchPc <= nextFetchPc;
    end
  end

  // relies on the exec bubble and the queue hiding its head on flush
  singleRedirect: assert property (@(posedge gclk) disable iff (grst)
    redirect |=> !redirect)
    else $error("redirect high on two consecutive cycles");

endmodule

// ==== aexmExecUnit.sv ====
`timescale 1ns/1ps
`include "aexm_defs.svh"

module aexmExecUnit
  import aexmIsaPkg::*, aexmPipePkg::*;
(
  input  logic   gclk,
  input  logic   grst,
  input  logic   popValid,
  input  pcT     popPc,
  input  instT   popInst,
  output logic   popReady,
  output logic   issue,
  output instT   issueInst,
  output pcT     issuePc,
  output wordT   regA,
  output pcT     target,
  output logic   retValid,
  output pcT     retPc,
  output regIdxT retRd,
  output logic   retWe,
  output wordT   retData
);

  wordT regFile [`AEXM_NREG];

  opcodeT opc;
  regIdxT rdIdx;
  regIdxT raIdx;
  immT    imm;
  wordT   immExt;
  wordT   wrData;
  logic   regWe;
  logic   isBranch;
  // set for the cycle after a branch issue
  logic   branchBubble;

  assign opc = instOpc(popInst);
  assign rdIdx = instRd(popInst);
  assign raIdx = instRa(popInst);
  assign imm = instImm(popInst);
  assign immExt = {{16{imm[15]}}, imm};

  assign isBranch = (opc == opBri) || (opc == opBcci);

  // one bubble after every branch, taken or not
  assign popReady = !branchBubble;
  assign issue = popValid && popReady;
  assign issueInst = popInst;
  assign issuePc = popPc;

  // r0 is hardwired zero
  assign regA = (raIdx == '0) ? '0 : regFile[raIdx];

  // immediate counts words, so no shift on the word address
  assign target = popPc + immExt[29:0];

  // result and write enable per opcode
  always_comb begin
    case (opc)
      opAddi: begin
        wrData = regA + immExt;
        regWe = 1'b1;
      end
      // link is the byte address of the branch itself
      opBri: begin
        wrData = {popPc, 2'b00};
        regWe = 1'b1;
      end
      default: begin
        wrData = '0;
        regWe = 1'b0;
      end
    endcase
    // writes to r0 are lost
    if (rdIdx == '0) begin
      regWe = 1'b0;
    end
  end

  // write lands before the next issue can read it
  always_ff @(posedge gclk) begin
    if (issue && regWe) begin
      regFile[rdIdx] <= wrData;
    end
  end

  always_ff @(posedge gclk) begin
    if (grst) begin
      branchBubble <= 1'b0;
      retValid <= 1'b0;
    end else begin
      branchBubble <= issue && isBranch;
      retValid <= issue;
    end
  end

  // retire payload, qualified by retValid
  always_ff @(posedge gclk) begin
    if (issue) begin
      retPc <= popPc;
      retRd <= rdIdx;
      retWe <= regWe;
      retData <= wrData;
    end
  end

endmodule

// ==== aexmFetchPort.sv ====
`timescale 1ns/1ps

module aexmFetchPort
  import aexmIsaPkg::*, aexmPipePkg::*;
(
  input  logic gclk,
  input  logic grst,
  input  pcT   fetchPc,
  output logic fetchAdvance,
  input  logic redirect,
  input  logic full,
  output logic pushValid,
  output pcT   pushPc,
  output instT pushInst,
  output wordT paddr,
  output logic psel,
  output logic penable,
  output logic pwrite,
  input  wordT prdata,
  input  logic pready
);

  fetchStateT state;
  fetchStateT nextState;
  // PC of the transfer on the bus
  pcT reqPc;

  // take a new PC only when idle, with queue room and no redirect
  // the queue cannot fill behind our back, only this port pushes
  assign fetchAdvance = (state == fsIdle) && !full && !redirect;

  always_comb begin
    nextState = state;
    case (state)
      fsIdle: begin
        if (fetchAdvance) begin
          nextState = fsSetup;
        end
      end
      // setup is always one cycle, access follows either way
      fsSetup: begin
        nextState = redirect ? fsDrop : fsAccess;
      end
      fsAccess: begin
        if (pready) begin
          nextState = fsIdle;
        end else if (redirect) begin
          nextState = fsDrop;
        end
      end
      // wait out the completer, data ignored
      fsDrop: begin
        if (pready) begin
          nextState = fsIdle;
        end
      end
      default: nextState = fsIdle;
    endcase
  end

  always_ff @(posedge gclk) begin
    if (grst) begin
      state <= fsIdle;
    end else begin
      state <= nextState;
    end
  end

  // latch the branch unit PC as we enter setup
  always_ff @(posedge gclk) begin
    if (fetchAdvance) begin
      reqPc <= fetchPc;
    end
  end

  // read only requester
  assign paddr   = {reqPc, 2'b00};
  assign psel    = (state != fsIdle);
  assign penable = (state == fsAccess) || (state == fsDrop);
  assign pwrite  = 1'b0;

  // push on the completing access cycle, unless the queue is being flushed
  assign pushValid = (state == fsAccess) && pready && !redirect;
  assign pushPc    = reqPc;
  assign pushInst  = prdata;

  // address held across setup and every wait cycle
  addrHeld: assert property (@(posedge gclk) disable iff (grst)
    (psel && !pready) |=> $stable(paddr))
    else $error("paddr changed during an open APB transfer");

endmodule

// ==== aexmFrontEnd.f ====
+incdir+.
aexmIsaPkg.sv
aexmPipePkg.sv
aexmFetchPort.sv
aexmInstQueue.sv
aexmExecUnit.sv
aexmBpcu.sv
aexmFrontEnd.sv
aexmFrontEndTb.sv

// ==== aexmFrontEnd.sv ====
`timescale 1ns/1ps

module aexmFrontEnd
  import aexmIsaPkg::*, aexmPipePkg::*;
(
  input  logic   gclk,
  input  logic   grst,
  output wordT   paddr,
  output logic   psel,
  output logic   penable,
  output logic   pwrite,
  input  wordT   prdata,
  input  logic   pready,
  output logic   retValid,
  output pcT     retPc,
  output regIdxT retRd,
  output logic   retWe,
  output wordT   retData
);

  // branch unit and fetch port
  pcT   fetchPc;
  logic fetchAdvance;
  logic redirect;
  pcT   redirectPc;
  // fetch port into queue
  logic full;
  logic pushValid;
  pcT   pushPc;
  instT pushInst;
  // queue into exec unit
  logic popValid;
  pcT   popPc;
  instT popInst;
  logic popReady;
  // exec unit into branch unit
  logic issue;
  instT issueInst;
  pcT   issuePc;
  wordT regA;
  pcT   target;

  aexmFetchPort aexmFetchPort_inst (
    .gclk(gclk), .grst(grst),
    .fetchPc(fetchPc), .fetchAdvance(fetchAdvance), .redirect(redirect),
    .full(full), .pushValid(pushValid), .pushPc(pushPc), .pushInst(pushInst),
    .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite),
    .prdata(prdata), .pready(pready)
  );

  // redirect flushes the queue
  aexmInstQueue aexmInstQueue_inst (
    .gclk(gclk), .grst(grst), .flush(redirect),
    .pushValid(pushValid), .pushPc(pushPc), .pushInst(pushInst), .full(full),
    .popValid(popValid), .popPc(popPc), .popInst(popInst), .popReady(popReady)
  );

  aexmExecUnit aexmExecUnit_inst (
    .gclk(gclk), .grst(grst),
    .popValid(popValid), .popPc(popPc), .popInst(popInst), .popReady(popReady),
    .issue(issue), .issueInst(issueInst), .issuePc(issuePc),
    .regA(regA), .target(target),
    .retValid(retValid), .retPc(retPc), .retRd(retRd), .retWe(retWe),
    .retData(retData)
  );

  aexmBpcu aexmBpcu_inst (
    .gclk(gclk), .grst(grst),
    .issue(issue), .issueInst(issueInst), .regA(regA), .target(target),
    .fetchAdvance(fetchAdvance), .fetchPc(fetchPc),
    .redirect(redirect), .redirectPc(redirectPc)
  );

endmodule

// ==== aexmFrontEndTb.sv ====
`timescale 1ns/1ps

module aexmFrontEndTb
  import aexmIsaPkg::*, aexmPipePkg::*;
();

  logic   gclk = 1'b0;
  logic   grst = 1'b1;
  wordT   paddr;
  logic   psel;
  logic   penable;
  logic   pwrite;
  wordT   prdata = '0;
  logic   pready = 1'b0;
  logic   retValid;
  pcT     retPc;
  regIdxT retRd;
  logic   retWe;
  wordT   retData;

  // program image indexed by word address
  logic [31:0] progMem [64];
  // byte addresses of completed transfers in bus order
  wordT doneAddr [$];
  // expected retire sequence
  pcT     expPc [$];
  regIdxT expRd [$];
  logic   expWe [$];
  wordT   expData [$];

  int checkCount = 0;
  int errorCount = 0;
  int timeoutCount = 0;
  logic [31:0] lcgState = 32'hebab4710;
  int waitLeft = 0;
  logic inAccess = 1'b0;
  // previous cycle was an APB setup cycle
  logic prevSetup = 1'b0;

  aexmFrontEnd aexmFrontEnd_inst (
    .gclk(gclk), .grst(grst),
    .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite),
    .prdata(prdata), .pready(pready),
    .retValid(retValid), .retPc(retPc), .retRd(retRd), .retWe(retWe),
    .retData(retData)
  );

  always #50 gclk = ~gclk;

  function automatic logic [31:0] nextRand();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState;
  endfunction

  // encodings straight from the field layout with octal opcodes
  function automatic logic [31:0] encAddi(regIdxT rd, regIdxT ra, logic [15:0] imm);
    return {6'o10, rd, ra, imm};
  endfunction

  // delay flag in ra bit 4
  function automatic logic [31:0] encBri(regIdxT rd, logic delay, logic [15:0] imm);
    return {6'o56, rd, delay, 4'b0000, imm};
  endfunction

  // delay flag in rd bit 4 and compare in rd 2:0
  function automatic logic [31:0] encBcc(logic [2:0] cond, logic delay, regIdxT ra,
                                         logic [15:0] imm);
    return {6'o57, delay, 1'b0, cond, ra, imm};
  endfunction

  task automatic checkVal(input string name, input logic [31:0] expVal,
                          input logic [31:0] actVal);
    checkCount++;
    if (actVal !== expVal) begin
      errorCount++;
      $display("[ERROR] %0t: %s expected %0h, got %0h", $time, name, expVal, actVal);
    end
  endtask

  // consume completed transfers up to the one at 4*pc
  task automatic matchFetch(input pcT pc);
    logic found;
    found = 1'b0;
    checkCount++;
    while (!found && doneAddr.size() > 0) begin
      if (doneAddr.pop_front() == {pc, 2'b00}) begin
        found = 1'b1;
      end
    end
    if (!found) begin
      errorCount++;
      $display("retired pc %0d was never read over APB at byte address %0h",
               pc, {pc, 2'b00});
    end
  endtask

  task automatic addExp(input pcT pc, input regIdxT rd, input logic we, input wordT data);
    expPc.push_back(pc);
    expRd.push_back(rd);
    expWe.push_back(we);
    expData.push_back(data);
  endtask

  task automatic loadTables();
    int i;
    int base;
    // r1 zero, r2 negative, r3 positive
    int takenReg [6] = '{1, 3, 2, 1, 3, 1};
    int missReg [6] = '{3, 1, 1, 3, 1, 2};
    // wrong-path marker whose immediate holds its own word address
    for (i = 0; i < 64; i++) begin
      progMem[i] = encAddi(5'd9, 5'd0, 16'(i));
    end
    // straight-line setup
    progMem[0] = encAddi(5'd1, 5'd0, 16'sd0);
    addExp(30'd0, 5'd1, 1'b1, 32'd0);
    progMem[1] = encAddi(5'd2, 5'd0, -16'sd5);
    addExp(30'd1, 5'd2, 1'b1, 32'hffff_fffb);
    progMem[2] = encAddi(5'd3, 5'd0, 16'sd7);
    addExp(30'd2, 5'd3, 1'b1, 32'd7);
    progMem[3] = encAddi(5'd3, 5'd3, 16'sd1);
    addExp(30'd3, 5'd3, 1'b1, 32'd8);
    progMem[4] = encAddi(5'd4, 5'd3, -16'sd3);
    addExp(30'd4, 5'd4, 1'b1, 32'd5);
    // one taken and one not-taken case per compare in words 5 to 28
    for (i = 0; i < 6; i++) begin
      base = 5 + 4 * i;
      // taken so base + 1 is skipped
      progMem[base] = encBcc(3'(i), 1'b0, 5'(takenReg[i]), 16'sd2);
      addExp(30'(base), 5'(i), 1'b0, 32'd0);
      // not taken and falls into the r5 counter
      progMem[base + 2] = encBcc(3'(i), 1'b0, 5'(missReg[i]), 16'sd2);
      addExp(30'(base + 2), 5'(i), 1'b0, 32'd0);
      progMem[base + 3] = encAddi(5'd5, (i == 0) ? 5'd0 : 5'd5, 16'sd1);
      addExp(30'(base + 3), 5'd5, 1'b1, 32'(i + 1));
    end
    // link without delay skips 30 and 31
    progMem[29] = encBri(5'd15, 1'b0, 16'sd3);
    addExp(30'd29, 5'd15, 1'b1, 32'd116);
    progMem[32] = encAddi(5'd6, 5'd15, 16'sd4);
    addExp(30'd32, 5'd6, 1'b1, 32'd120);
    // link with delay slot at 34
    progMem[33] = encBri(5'd16, 1'b1, 16'sd4);
    addExp(30'd33, 5'd16, 1'b1, 32'd132);
    progMem[34] = encAddi(5'd7, 5'd0, 16'sd11);
    addExp(30'd34, 5'd7, 1'b1, 32'd11);
    // delayed NE taken with its slot at 38
    progMem[37] = encBcc(3'd1, 1'b1, 5'd3, 16'sd3);
    addExp(30'd37, 5'd17, 1'b0, 32'd0);
    progMem[38] = encAddi(5'd7, 5'd7, 16'sd1);
    addExp(30'd38, 5'd7, 1'b1, 32'd12);
    // delay bit on a branch that falls through
    progMem[40] = encBcc(3'd0, 1'b1, 5'd3, 16'sd5);
    addExp(30'd40, 5'd16, 1'b0, 32'd0);
    progMem[41] = encAddi(5'd8, 5'd0, -16'sd1);
    addExp(30'd41, 5'd8, 1'b1, 32'hffff_ffff);
    // long accumulate run
    for (i = 42; i < 54; i++) begin
      progMem[i] = encAddi(5'd8, 5'd8, 16'sd3);
      addExp(30'(i), 5'd8, 1'b1, 32'(3 * (i - 42) + 2));
    end
    // parking loop that branches to itself
    progMem[54] = encBri(5'd17, 1'b0, 16'sd0);
    addExp(30'd54, 5'd17, 1'b1, 32'd216);
  endtask

  // APB completer with 0 to 2 wait cycles per transfer
  always @(posedge gclk) begin
    #1;
    if (grst || !(psel && penable)) begin
      pready = 1'b0;
      inAccess = 1'b0;
    end else begin
      if (!inAccess) begin
        inAccess = 1'b1;
        waitLeft = int'((nextRand() >> 16) % 32'd3);
        // access must follow a setup cycle
        checkVal("psel setup cycle", 32'd1, 32'(prevSetup));
        checkVal("paddr[1:0]", 32'd0, 32'(paddr[1:0]));
        checkVal("pwrite", 32'd0, 32'(pwrite));
      end
      if (waitLeft == 0) begin
        pready = 1'b1;
        doneAddr.push_back(paddr);
        if (paddr < 32'd256) begin
          prdata = progMem[paddr[7:2]];
        end else begin
          prdata = encAddi(5'd9, 5'd0, paddr[17:2] ^ paddr[31:16]);
        end
      end else begin
        pready = 1'b0;
        waitLeft--;
      end
    end
    prevSetup = psel && !penable;
  end

  // one sample per cycle just after the edge
  task automatic waitRetire(output logic ok);
    int n;
    ok = 1'b0;
    for (n = 0; n < 200; n++) begin
      @(posedge gclk);
      #1;
      if (retValid) begin
        ok = 1'b1;
        break;
      end
    end
  endtask

  initial begin
    int idx;
    logic gotOne;
    logic timedOut;
    timedOut = 1'b0;
    loadTables();
    repeat (10) @(posedge gclk);
    #1;
    // quiet outputs while held in reset
    checkVal("psel", 32'd0, 32'(psel));
    checkVal("penable", 32'd0, 32'(penable));
    checkVal("retValid", 32'd0, 32'(retValid));
    grst = 1'b0;
    for (idx = 0; idx < expPc.size() && !timedOut; idx++) begin
      waitRetire(gotOne);
      if (!gotOne) begin
        $display("timeout: nothing retired in 200 cycles, waiting for pc %0d", expPc[idx]);
        timeoutCount++;
        timedOut = 1'b1;
      end else begin
        checkVal("retPc", 32'(expPc[idx]), 32'(retPc));
        checkVal("retRd", 32'(expRd[idx]), 32'(retRd));
        checkVal("retWe", 32'(expWe[idx]), 32'(retWe));
        if (expWe[idx]) begin
          checkVal("retData", expData[idx], retData);
        end
        // retired word must have been read from paddr 4*pc after the previous one
        matchFetch(retPc);
      end
    end
    $display("%0d checks, %0d value errors, %0d timeouts",
             checkCount, errorCount, timeoutCount);
    if (errorCount == 0 && timeoutCount == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// ==== aexmInstQueue.sv ====
`timescale 1ns/1ps
`include "aexm_defs.svh"

module aexmInstQueue
  import aexmIsaPkg::*, aexmPipePkg::*;
(
  input  logic gclk,
  input  logic grst,
  input  logic flush,
  input  logic pushValid,
  input  pcT   pushPc,
  input  instT pushInst,
  output logic full,
  output logic popValid,
  output pcT   popPc,
  output instT popInst,
  input  logic popReady
);

  localparam int QDepth = `AEXM_QDEPTH;
  localparam int PtrW = $clog2(QDepth);
  localparam int CntW = $clog2(QDepth + 1);

  pcT   pcMem   [QDepth];
  instT instMem [QDepth];

  logic [PtrW-1:0] wrPtr;
  logic [PtrW-1:0] rdPtr;
  logic [CntW-1:0] count;
  logic doPush;
  logic doPop;

  assign full = (count == CntW'(QDepth));
  // head hidden while flushing so nothing on the wrong path issues
  assign popValid = (count != '0) && !flush;
  assign popPc = pcMem[rdPtr];
  assign popInst = instMem[rdPtr];

  assign doPush = pushValid && !full;
  assign doPop = popValid && popReady;

  // pointers wrap naturally, depth is a power of two
  always_ff @(posedge gclk) begin
    if (grst || flush) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      if (doPush) begin
        wrPtr <= wrPtr + 1'b1;
      end
      if (doPop) begin
        rdPtr <= rdPtr + 1'b1;
      end
      count <= count + CntW'(doPush) - CntW'(doPop);
    end
  end

  always_ff @(posedge gclk) begin
    if (doPush) begin
      pcMem[wrPtr] <= pushPc;
      instMem[wrPtr] <= pushInst;
    end
  end

  // fetch port must hold off while full
  noPushFull: assert property (@(posedge gclk) disable iff (grst)
    pushValid |-> !full)
    else $error("push into a full instruction queue");

  // empty with nothing arriving leaves nothing to pop next cycle
  noPopEmpty: assert property (@(posedge gclk) disable iff (grst)
    (count == '0 && !pushValid) |=> !popValid)
    else $error("pop offered from an empty instruction queue");

endmodule

// ==== aexmIsaPkg.sv ====
package aexmIsaPkg;

  // major opcodes, octal as in the ISA manual
  typedef enum logic [5:0] {
    opAddi = 6'o10,
    opBri  = 6'o56,
    opBcci = 6'o57
  } opcodeT;

  typedef logic [4:0] regIdxT;
  typedef logic signed [15:0] immT;

  // conditional branch compare, taken from rd[2:0]
  typedef enum logic [2:0] {
    condEq = 3'd0,
    condNe = 3'd1,
    condLt = 3'd2,
    condLe = 3'd3,
    condGt = 3'd4,
    condGe = 3'd5
  } condT;

  // opcode 31:26, rd 25:21, ra 20:16, imm 15:0
  typedef logic [31:0] instT;

  // field extraction
  function automatic opcodeT instOpc(instT inst);
    return opcodeT'(inst[31:26]);
  endfunction

  function automatic regIdxT instRd(instT inst);
    return inst[25:21];
  endfunction

  function automatic regIdxT instRa(instT inst);
    return inst[20:16];
  endfunction

  function automatic immT instImm(instT inst);
    return immT'(inst[15:0]);
  endfunction

endpackage

// ==== aexmPipePkg.sv ====
package aexmPipePkg;

  // data word on the register and bus side
  typedef logic [31:0] wordT;

  // word address, byte address bits 31:2
  typedef logic [29:0] pcT;

  // APB read requester states
  // fsDrop finishes a transfer whose data is thrown away
  typedef enum logic [1:0] {
    fsIdle   = 2'd0,
    fsSetup  = 2'd1,
    fsAccess = 2'd2,
    fsDrop   = 2'd3
  } fetchStateT;

endpackage

// ==== aexm_defs.svh ====
`ifndef AEXM_DEFS_SVH
`define AEXM_DEFS_SVH

// instruction queue entries, power of two
`define AEXM_QDEPTH 4

// register file size
`define AEXM_NREG 32

// first fetch word address
`define AEXM_RESET_PC 30'd0

`endif
